// ==== verilog.f ====
rtl/core_pkg.sv
rtl/rob_pkg.sv
rtl/rob_alloc.sv
rtl/rob_entry.sv
rtl/rob_commit.sv
rtl/rob_top.sv
test/tb_clock.sv
test/rob_props.sv
test/rob_tb.sv

// ==== Makefile ====
# Verilator build and run for the reorder buffer testbench

VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Status comes from the pass line in the simulator output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== test/rob_tb.sv ====
// Reorder buffer testbench
`timescale 1ns/1ps
`default_nettype none

module rob_tb
    import core_pkg::*;
    import rob_pkg::*;
();

    localparam int          TIMEOUT        = 200;
    localparam int          STREAM_LEN     = 40;
    localparam int          SIG_ALLOC_ACK  = 0;
    localparam int          SIG_COMMIT_REQ = 1;
    localparam logic [31:0] SEED           = 32'hc9b2_133e;

    logic     clk;
    logic     reset;
    logic     alloc_req;
    pc_t      alloc_pc;
    word_t    alloc_inst;
    preg_t    alloc_prd;
    logic     alloc_ack;
    rob_idx_t alloc_idx;
    logic     full;
    logic     wb_alu_valid;
    rob_idx_t wb_alu_idx;
    word_t    wb_alu_value;
    logic     wb_lsu_valid;
    rob_idx_t wb_lsu_idx;
    word_t    wb_lsu_value;
    logic     wb_mul_valid;
    rob_idx_t wb_mul_idx;
    word_t    wb_mul_value;
    logic     commit_req;
    logic     commit_ack;
    pc_t      commit_pc;
    word_t    commit_inst;
    preg_t    commit_prd;
    word_t    commit_value;
    logic     empty;

    // Expected record per slot, filled on ack and on writeback
    pc_t      exp_pc    [ROB_ENTRIES];
    word_t    exp_inst  [ROB_ENTRIES];
    preg_t    exp_prd   [ROB_ENTRIES];
    word_t    exp_val   [ROB_ENTRIES];
    // Slots in allocation order, and slots still waiting for a result
    rob_idx_t order_q   [$];
    rob_idx_t pending_q [$];
    rob_idx_t tail_model;
    pc_t      next_pc;
    logic [31:0] lfsr;
    int       errors;
    int       tests_run;
    int       tests_failed;
    int       test_start_errors;

    tb_clock u_clock (
        .clk_o (clk)
    );

    rob_top DUT (
        .clk_i          (clk),
        .reset_i        (reset),
        .alloc_req_i    (alloc_req),
        .alloc_pc_i     (alloc_pc),
        .alloc_inst_i   (alloc_inst),
        .alloc_prd_i    (alloc_prd),
        .alloc_ack_o    (alloc_ack),
        .alloc_idx_o    (alloc_idx),
        .full_o         (full),
        .wb_alu_valid_i (wb_alu_valid),
        .wb_alu_idx_i   (wb_alu_idx),
        .wb_alu_value_i (wb_alu_value),
        .wb_lsu_valid_i (wb_lsu_valid),
        .wb_lsu_idx_i   (wb_lsu_idx),
        .wb_lsu_value_i (wb_lsu_value),
        .wb_mul_valid_i (wb_mul_valid),
        .wb_mul_idx_i   (wb_mul_idx),
        .wb_mul_value_i (wb_mul_value),
        .commit_req_o   (commit_req),
        .commit_ack_i   (commit_ack),
        .commit_pc_o    (commit_pc),
        .commit_inst_o  (commit_inst),
        .commit_prd_o   (commit_prd),
        .commit_value_o (commit_value),
        .empty_o        (empty)
    );

    bind rob_top rob_props u_props (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .alloc_req_i    (alloc_req_i),
        .alloc_ack_i    (alloc_ack_o),
        .full_i         (full_o),
        .empty_i        (empty_o),
        .commit_req_i   (commit_req_o),
        .commit_ack_i   (commit_ack_i),
        .commit_pc_i    (commit_pc_o),
        .commit_inst_i  (commit_inst_o),
        .commit_prd_i   (commit_prd_o),
        .commit_value_i (commit_value_o)
    );

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic probe(input int sel);
        if (sel == SIG_ALLOC_ACK) begin
            return alloc_ack;
        end
        return commit_req;
    endfunction

    task automatic finish_report();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout at %0t: no %s within %0d cycles", $time, what, TIMEOUT);
        errors++;
        finish_report();
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    // Sampled on falling edges, away from the DUT's update edge
    task automatic wait_for(input int sel, input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (probe(sel) !== level && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (probe(sel) !== level) begin
            timeout_fail(what);
        end
    endtask

    // Four-phase dispatch, record kept under the returned index
    task automatic dispatch(input pc_t pc, input word_t inst, input preg_t prd);
        @(posedge clk);
        alloc_req  <= 1'b1;
        alloc_pc   <= pc;
        alloc_inst <= inst;
        alloc_prd  <= prd;
        wait_for(SIG_ALLOC_ACK, 1'b1, "alloc_ack_o rise");
        check_field("alloc_idx_o", 32'(alloc_idx), 32'(tail_model));
        exp_pc[alloc_idx]   = pc;
        exp_inst[alloc_idx] = inst;
        exp_prd[alloc_idx]  = prd;
        order_q.push_back(alloc_idx);
        pending_q.push_back(alloc_idx);
        tail_model = tail_model + 1'b1;
        @(posedge clk);
        alloc_req <= 1'b0;
        wait_for(SIG_ALLOC_ACK, 1'b0, "alloc_ack_o fall");
    endtask

    task automatic dispatch_next();
        next_pc = next_pc + 32'd4;
        dispatch(next_pc, {next_pc[15:0], 16'h0033}, preg_t'(next_pc[6:2]));
    endtask

    // Unit 0 ALU, 1 LSU, else MUL
    task automatic drive_unit(input int unit, input rob_idx_t idx, input word_t value);
        case (unit)
            0: begin
                wb_alu_valid <= 1'b1;
                wb_alu_idx   <= idx;
                wb_alu_value <= value;
            end
            1: begin
                wb_lsu_valid <= 1'b1;
                wb_lsu_idx   <= idx;
                wb_lsu_value <= value;
            end
            default: begin
                wb_mul_valid <= 1'b1;
                wb_mul_idx   <= idx;
                wb_mul_value <= value;
            end
        endcase
        exp_val[idx] = value;
    endtask

    task automatic clear_strobes();
        wb_alu_valid <= 1'b0;
        wb_lsu_valid <= 1'b0;
        wb_mul_valid <= 1'b0;
    endtask

    // One-cycle strobe
    task automatic writeback_one(input int unit, input rob_idx_t idx, input word_t value);
        @(posedge clk);
        drive_unit(unit, idx, value);
        @(posedge clk);
        clear_strobes();
    endtask

    task automatic writeback_random();
        int       k;
        rob_idx_t idx;
        k   = int'(rand_bits(3)) % pending_q.size();
        idx = pending_q[k];
        pending_q.delete(k);
        writeback_one(int'(rand_bits(2)) % 3, idx, rand_bits(32));
    endtask

    task automatic stream_writebacks(input int count);
        int done_n;
        int idle;
        done_n = 0;
        idle   = 0;
        while (done_n < count) begin
            if (pending_q.size() == 0) begin
                @(posedge clk);
                idle++;
                if (idle > TIMEOUT) begin
                    timeout_fail("dispatched entry to write back");
                end
            end else begin
                writeback_random();
                done_n++;
                idle = 0;
            end
        end
    endtask

    // Check against oldest dispatch, ack after a random delay
    task automatic commit_one();
        rob_idx_t idx;
        int       delay;
        wait_for(SIG_COMMIT_REQ, 1'b1, "commit_req_o rise");
        if (order_q.size() == 0) begin
            $display("commit request at %0t with nothing outstanding", $time);
            errors++;
        end else begin
            idx = order_q.pop_front();
            check_field("commit_pc_o", commit_pc, exp_pc[idx]);
            check_field("commit_inst_o", commit_inst, exp_inst[idx]);
            check_field("commit_prd_o", 32'(commit_prd), 32'(exp_prd[idx]));
            check_field("commit_value_o", commit_value, exp_val[idx]);
        end
        delay = int'(rand_bits(2));
        repeat (delay) @(posedge clk);
        @(posedge clk);
        commit_ack <= 1'b1;
        wait_for(SIG_COMMIT_REQ, 1'b0, "commit_req_o fall");
        @(posedge clk);
        commit_ack <= 1'b0;
    endtask

    initial begin
        rob_idx_t head_idx;
        lfsr              = SEED;
        errors            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        test_start_errors = 0;
        tail_model        = '0;
        next_pc           = 32'h0000_1000;
        reset        <= 1'b1;
        alloc_req    <= 1'b0;
        alloc_pc     <= '0;
        alloc_inst   <= '0;
        alloc_prd    <= '0;
        wb_alu_valid <= 1'b0;
        wb_alu_idx   <= '0;
        wb_alu_value <= '0;
        wb_lsu_valid <= 1'b0;
        wb_lsu_idx   <= '0;
        wb_lsu_value <= '0;
        wb_mul_valid <= 1'b0;
        wb_mul_idx   <= '0;
        wb_mul_value <= '0;
        commit_ack   <= 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        // Idle outputs right out of reset
        check_field("empty_o", 32'(empty), 32'd1);
        check_field("full_o", 32'(full), 32'd0);
        check_field("alloc_ack_o", 32'(alloc_ack), 32'd0);
        check_field("commit_req_o", 32'(commit_req), 32'd0);
        end_test("reset");

        // One instruction through the ALU
        dispatch(32'h0000_0800, 32'h0010_0093, preg_t'(5'd9));
        head_idx = pending_q.pop_front();
        writeback_one(0, head_idx, 32'hdead_0001);
        commit_one();
        @(negedge clk);
        check_field("empty_o", 32'(empty), 32'd1);
        end_test("single");

        // Eight in flight, finished in random order
        repeat (ROB_ENTRIES) dispatch_next();
        stream_writebacks(ROB_ENTRIES);
        repeat (ROB_ENTRIES) commit_one();
        end_test("out_of_order");

        // Ninth request stalls until the head retires
        repeat (ROB_ENTRIES) dispatch_next();
        check_field("full_o", 32'(full), 32'd1);
        fork
            dispatch_next();
            begin
                repeat (6) begin
                    @(negedge clk);
                    check_field("alloc_ack_o", 32'(alloc_ack), 32'd0);
                end
                head_idx = pending_q.pop_front();
                writeback_one(1, head_idx, rand_bits(32));
                commit_one();
            end
        join
        stream_writebacks(ROB_ENTRIES);
        repeat (ROB_ENTRIES) commit_one();
        end_test("full");

        // All three units hit different slots in one cycle
        repeat (3) dispatch_next();
        @(posedge clk);
        drive_unit(0, pending_q[2], 32'h1111_aaaa);
        drive_unit(1, pending_q[0], 32'h2222_bbbb);
        drive_unit(2, pending_q[1], 32'h3333_cccc);
        @(posedge clk);
        clear_strobes();
        pending_q.delete();
        repeat (3) commit_one();
        end_test("same_cycle_wb");

        // Long stream, pointers wrap several times
        fork
            repeat (STREAM_LEN) dispatch_next();
            stream_writebacks(STREAM_LEN);
            repeat (STREAM_LEN) commit_one();
        join
        end_test("wraparound");

        finish_report();
    end

endmodule

`default_nettype wire

// ==== test/rob_props.sv ====
// ROB protocol assertions
`timescale 1ns/1ps
`default_nettype none

module rob_props
    import core_pkg::*;
(
    input logic  clk_i,
    input logic  reset_i,
    input logic  alloc_req_i,
    input logic  alloc_ack_i,
    input logic  full_i,
    input logic  empty_i,
    input logic  commit_req_i,
    input logic  commit_ack_i,
    input pc_t   commit_pc_i,
    input word_t commit_inst_i,
    input preg_t commit_prd_i,
    input word_t commit_value_i
);

    // Tail slot busy and head slot free are exclusive
    full_empty_excl: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(full_i && empty_i)
    ) else $error("full_o and empty_o high in the same cycle");

    // Retirement record held for the whole request
    commit_fields_stable: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (commit_req_i && $past(commit_req_i)) |->
            ($stable(commit_pc_i) && $stable(commit_inst_i) &&
             $stable(commit_prd_i) && $stable(commit_value_i))
    ) else $error("commit outputs changed while commit_req_o was high");

    // Request only drops once the consumer has acked
    commit_req_drop: assert property (
        @(posedge clk_i) disable iff (reset_i)
        $fell(commit_req_i) |-> $past(commit_ack_i)
    ) else $error("commit_req_o fell without commit_ack_i");

    // Ack answers a live request
    alloc_ack_rise: assert property (
        @(posedge clk_i) disable iff (reset_i)
        $rose(alloc_ack_i) |-> $past(alloc_req_i)
    ) else $error("alloc_ack_o rose without alloc_req_i");

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
// Testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_o
);

    // Half of the 4 ns period
    localparam int HALF_PERIOD_NS = 2;

    // Low at time zero, first rising edge at 2 ns
    initial begin
        clk_o = 1'b0;
    end

    always #(HALF_PERIOD_NS) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== rtl/rob_top.sv ====
// Reorder buffer top level
`timescale 1ns/1ps
`default_nettype none

module rob_top
    import core_pkg::*;
    import rob_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_i,
    // Dispatch
    input  logic     alloc_req_i,
    input  pc_t      alloc_pc_i,
    input  word_t    alloc_inst_i,
    input  preg_t    alloc_prd_i,
    output logic     alloc_ack_o,
    output rob_idx_t alloc_idx_o,
    output logic     full_o,
    // Writeback strobes
    input  logic     wb_alu_valid_i,
    input  rob_idx_t wb_alu_idx_i,
    input  word_t    wb_alu_value_i,
    input  logic     wb_lsu_valid_i,
    input  rob_idx_t wb_lsu_idx_i,
    input  word_t    wb_lsu_value_i,
    input  logic     wb_mul_valid_i,
    input  rob_idx_t wb_mul_idx_i,
    input  word_t    wb_mul_value_i,
    // Retirement
    output logic     commit_req_o,
    input  logic     commit_ack_i,
    output pc_t      commit_pc_o,
    output word_t    commit_inst_o,
    output preg_t    commit_prd_o,
    output word_t    commit_value_o,
    output logic     empty_o
);

    logic                    alloc_en;
    rob_idx_t                alloc_slot;
    logic                    retire_en;
    rob_idx_t                retire_slot;

    // Per-slot state gathered for the head select
    logic  [ROB_ENTRIES-1:0] entry_valid;
    logic  [ROB_ENTRIES-1:0] entry_done;
    pc_t   [ROB_ENTRIES-1:0] entry_pc;
    word_t [ROB_ENTRIES-1:0] entry_inst;
    preg_t [ROB_ENTRIES-1:0] entry_prd;
    word_t [ROB_ENTRIES-1:0] entry_value;

    rob_alloc u_alloc (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .alloc_req_i   (alloc_req_i),
        .entry_valid_i (entry_valid),
        .alloc_ack_o   (alloc_ack_o),
        .alloc_idx_o   (alloc_idx_o),
        .alloc_en_o    (alloc_en),
        .alloc_slot_o  (alloc_slot),
        .full_o        (full_o)
    );

    // Eight identical slots
    for (genvar i = 0; i < ROB_ENTRIES; i++) begin : g_entry
        rob_entry #(
            .ENTRY_IDX (i)
        ) u_entry (
            .clk_i          (clk_i),
            .reset_i        (reset_i),
            .alloc_en_i     (alloc_en),
            .alloc_slot_i   (alloc_slot),
            .alloc_pc_i     (alloc_pc_i),
            .alloc_inst_i   (alloc_inst_i),
            .alloc_prd_i    (alloc_prd_i),
            .wb_alu_valid_i (wb_alu_valid_i),
            .wb_alu_idx_i   (wb_alu_idx_i),
            .wb_alu_value_i (wb_alu_value_i),
            .wb_lsu_valid_i (wb_lsu_valid_i),
            .wb_lsu_idx_i   (wb_lsu_idx_i),
            .wb_lsu_value_i (wb_lsu_value_i),
            .wb_mul_valid_i (wb_mul_valid_i),
            .wb_mul_idx_i   (wb_mul_idx_i),
            .wb_mul_value_i (wb_mul_value_i),
            .retire_en_i    (retire_en),
            .retire_slot_i  (retire_slot),
            .valid_o        (entry_valid[i]),
            .done_o         (entry_done[i]),
            .pc_o           (entry_pc[i]),
            .inst_o         (entry_inst[i]),
            .prd_o          (entry_prd[i]),
            .value_o        (entry_value[i])
        );
    end

    rob_commit u_commit (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .commit_ack_i   (commit_ack_i),
        .entry_valid_i  (entry_valid),
        .entry_done_i   (entry_done),
        .entry_pc_i     (entry_pc),
        .entry_inst_i   (entry_inst),
        .entry_prd_i    (entry_prd),
        .entry_value_i  (entry_value),
        .retire_en_o    (retire_en),
        .retire_slot_o  (retire_slot),
        .empty_o        (empty_o),
        .commit_req_o   (commit_req_o),
        .commit_pc_o    (commit_pc_o),
        .commit_inst_o  (commit_inst_o),
        .commit_prd_o   (commit_prd_o),
        .commit_value_o (commit_value_o)
    );

endmodule

`default_nettype wire

// ==== rtl/rob_commit.sv ====
// ROB in-order commit stage
`timescale 1ns/1ps
`default_nettype none

module rob_commit
    import core_pkg::*;
    import rob_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   commit_ack_i,
    // Packed views of all slots
    input  logic [ROB_ENTRIES-1:0] entry_valid_i,
    input  logic [ROB_ENTRIES-1:0] entry_done_i,
    input  pc_t  [ROB_ENTRIES-1:0] entry_pc_i,
    input  word_t [ROB_ENTRIES-1:0] entry_inst_i,
    input  preg_t [ROB_ENTRIES-1:0] entry_prd_i,
    input  word_t [ROB_ENTRIES-1:0] entry_value_i,
    // Slot free
    output logic                   retire_en_o,
    output rob_idx_t               retire_slot_o,
    output logic                   empty_o,
    // Retirement request
    output logic                   commit_req_o,
    output pc_t                    commit_pc_o,
    output word_t                  commit_inst_o,
    output preg_t                  commit_prd_o,
    output word_t                  commit_value_o
);

    hs_state_t state_q;
    rob_idx_t  head_q;
    rob_idx_t  head_next;
    logic      head_valid;
    logic      head_ready;

    pc_t       pc_q;
    word_t     inst_q;
    preg_t     prd_q;
    word_t     value_q;

    assign head_next  = (head_q == rob_idx_t'(ROB_ENTRIES - 1)) ? '0 : head_q + 1'b1;
    assign head_valid = entry_valid_i[head_q];

    // Oldest instruction has its result
    assign head_ready = head_valid && entry_done_i[head_q];

    assign empty_o = !head_valid;

    // Free the head slot on the ack edge
    assign retire_en_o   = (state_q == HS_ACK) && commit_ack_i;
    assign retire_slot_o = head_q;

    assign commit_req_o = (state_q == HS_ACK);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= HS_IDLE;
            head_q  <= '0;
        end else begin
            case (state_q)
                HS_IDLE: begin
                    if (head_ready) begin
                        state_q <= HS_ACK;
                    end
                end
                HS_ACK: begin
                    // Retire, advance and drop req together
                    if (commit_ack_i) begin
                        state_q <= HS_WAIT_DROP;
                        head_q  <= head_next;
                    end
                end
                HS_WAIT_DROP: begin
                    // Hold off until the consumer releases ack
                    if (!commit_ack_i) begin
                        state_q <= HS_IDLE;
                    end
                end
                default: begin
                    state_q <= HS_IDLE;
                end
            endcase
        end
    end

    // Head record latched as the request rises, stable until ack
    always_ff @(posedge clk_i) begin
        if ((state_q == HS_IDLE) && head_ready) begin
            pc_q    <= entry_pc_i[head_q];
            inst_q  <= entry_inst_i[head_q];
            prd_q   <= entry_prd_i[head_q];
            value_q <= entry_value_i[head_q];
        end
    end

    assign commit_pc_o    = pc_q;
    assign commit_inst_o  = inst_q;
    assign commit_prd_o   = prd_q;
    assign commit_value_o = value_q;

endmodule

`default_nettype wire

// ==== rtl/rob_entry.sv ====
// Single ROB slot
`timescale 1ns/1ps
`default_nettype none

module rob_entry
    import core_pkg::*;
    import rob_pkg::*;
#(
    parameter int ENTRY_IDX = 0
) (
    input  logic     clk_i,
    input  logic     reset_i,
    // Dispatch write
    input  logic     alloc_en_i,
    input  rob_idx_t alloc_slot_i,
    input  pc_t      alloc_pc_i,
    input  word_t    alloc_inst_i,
    input  preg_t    alloc_prd_i,
    // ALU writeback
    input  logic     wb_alu_valid_i,
    input  rob_idx_t wb_alu_idx_i,
    input  word_t    wb_alu_value_i,
    // Load/store writeback
    input  logic     wb_lsu_valid_i,
    input  rob_idx_t wb_lsu_idx_i,
    input  word_t    wb_lsu_value_i,
    // Multiplier writeback
    input  logic     wb_mul_valid_i,
    input  rob_idx_t wb_mul_idx_i,
    input  word_t    wb_mul_value_i,
    // Retirement free
    input  logic     retire_en_i,
    input  rob_idx_t retire_slot_i,
    // Slot contents
    output logic     valid_o,
    output logic     done_o,
    output pc_t      pc_o,
    output word_t    inst_o,
    output preg_t    prd_o,
    output word_t    value_o
);

    localparam rob_idx_t MY_IDX = rob_idx_t'(ENTRY_IDX);

    logic  valid_q;
    logic  done_q;
    pc_t   pc_q;
    word_t inst_q;
    preg_t prd_q;
    word_t value_q;

    logic  alloc_hit;
    logic  retire_hit;
    logic  alu_hit;
    logic  lsu_hit;
    logic  mul_hit;
    logic  wb_hit;
    word_t wb_value;

    assign alloc_hit  = alloc_en_i && (alloc_slot_i == MY_IDX);
    assign retire_hit = retire_en_i && (retire_slot_i == MY_IDX);

    // Writeback only lands on a busy slot
    assign alu_hit = wb_alu_valid_i && (wb_alu_idx_i == MY_IDX) && valid_q && !done_q;
    assign lsu_hit = wb_lsu_valid_i && (wb_lsu_idx_i == MY_IDX) && valid_q && !done_q;
    assign mul_hit = wb_mul_valid_i && (wb_mul_idx_i == MY_IDX) && valid_q && !done_q;
    assign wb_hit  = alu_hit || lsu_hit || mul_hit;

    // At most one unit targets this slot per cycle
    always_comb begin
        wb_value = wb_alu_value_i;
        if (lsu_hit) begin
            wb_value = wb_lsu_value_i;
        end else if (mul_hit) begin
            wb_value = wb_mul_value_i;
        end
    end

    // Busy/done state
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            done_q  <= 1'b0;
        end else if (alloc_hit) begin
            valid_q <= 1'b1;
            done_q  <= 1'b0;
        end else if (retire_hit) begin
            valid_q <= 1'b0;
            done_q  <= 1'b0;
        end else if (wb_hit) begin
            done_q <= 1'b1;
        end
    end

    // Instruction record and result
    always_ff @(posedge clk_i) begin
        if (alloc_hit) begin
            pc_q   <= alloc_pc_i;
            inst_q <= alloc_inst_i;
            prd_q  <= alloc_prd_i;
        end
        if (wb_hit) begin
            value_q <= wb_value;
        end
    end

    assign valid_o = valid_q;
    assign done_o  = done_q;
    assign pc_o    = pc_q;
    assign inst_o  = inst_q;
    assign prd_o   = prd_q;
    assign value_o = value_q;

endmodule

`default_nettype wire

// ==== rtl/rob_alloc.sv ====
// ROB allocation handshake
`timescale 1ns/1ps
`default_nettype none

module rob_alloc
    import rob_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   alloc_req_i,
    input  logic [ROB_ENTRIES-1:0] entry_valid_i,
    output logic                   alloc_ack_o,
    output rob_idx_t               alloc_idx_o,
    output logic                   alloc_en_o,
    output rob_idx_t               alloc_slot_o,
    output logic                   full_o
);

    hs_state_t state_q;
    rob_idx_t  tail_q;
    rob_idx_t  tail_next;
    rob_idx_t  idx_q;

    // Tail wraps back to slot zero
    assign tail_next = (tail_q == rob_idx_t'(ROB_ENTRIES - 1)) ? '0 : tail_q + 1'b1;

    // Next slot to fill is still occupied
    assign full_o = entry_valid_i[tail_q];

    // One write per handshake, only from idle
    assign alloc_en_o   = (state_q == HS_IDLE) && alloc_req_i && !full_o;
    assign alloc_slot_o = tail_q;

    // Ack held through both closing states
    assign alloc_ack_o = (state_q != HS_IDLE);
    assign alloc_idx_o = idx_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= HS_IDLE;
            tail_q  <= '0;
        end else begin
            case (state_q)
                HS_IDLE: begin
                    // Slot written and ack raised on this edge
                    if (alloc_en_o) begin
                        state_q <= HS_ACK;
                        tail_q  <= tail_next;
                    end
                end
                HS_ACK: begin
                    // Source has seen the ack
                    if (!alloc_req_i) begin
                        state_q <= HS_WAIT_DROP;
                    end
                end
                HS_WAIT_DROP: begin
                    // Ack falls one cycle after req low
                    state_q <= HS_IDLE;
                end
                default: begin
                    state_q <= HS_IDLE;
                end
            endcase
        end
    end

    // Slot number reported with the ack
    always_ff @(posedge clk_i) begin
        if (alloc_en_o) begin
            idx_q <= tail_q;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rob_pkg.sv ====
// Reorder buffer geometry and handshake states
`default_nettype none

package rob_pkg;

    // Number of buffer slots
    localparam int ROB_ENTRIES = 8;

    // Slot index width, 3 bits for eight slots
    localparam int ROB_IDX_W = $clog2(ROB_ENTRIES);

    // Index into the buffer, also handed back to dispatch
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    // Four-phase handshake progress
    // HS_IDLE: nothing in flight
    // HS_ACK: transfer done, waiting on the other side
    // HS_WAIT_DROP: closing out the handshake
    typedef enum logic [1:0] {
        HS_IDLE,
        HS_ACK,
        HS_WAIT_DROP
    } hs_state_t;

endpackage

`default_nettype wire

// ==== rtl/core_pkg.sv ====
// Core data widths and types
`default_nettype none

package core_pkg;

    // Architectural word width for RV32
    localparam int XLEN = 32;

    // Physical register file depth and address width
    localparam int PREG_W = 5;

    // Instruction words and result values
    typedef logic [XLEN-1:0] word_t;

    // Program counters
    typedef logic [XLEN-1:0] pc_t;

    // Destination physical register address
    typedef logic [PREG_W-1:0] preg_t;

endpackage

`default_nettype wire
